//--- Makefile
# Verilator build of the memory and write-back testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_wb_top
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= SIMULATION PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# pass only if the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/data_ram.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module data_ram (
    input logic      clk,
    mem_bus_if.slave bus
);
    import pipe_pkg::*;

    word_t     mem_q [`PIPE_RAM_WORDS];
    ram_addr_t widx;  // word index, byte offset dropped

    assign widx = bus.addr[$bits(ram_addr_t)+1:2];

    // byte-lane write
    always_ff @(posedge clk) begin
        if (bus.en && bus.we) begin
            for (int b = 0; b < $bits(wmask_t); b++) begin
                if (bus.wmask[b]) begin
                    mem_q[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // async read, zero when idle
    assign bus.rdata = bus.en ? mem_q[widx] : '0;

    // upper address bits are not decoded, so an access past the end would alias
    a_addr_range: assert property (@(posedge clk)
        bus.en |-> ((bus.addr >> 2) < `PIPE_RAM_WORDS))
        else $error("data_ram: address 0x%08h out of range", bus.addr);

endmodule

//--- hdl/mem_bus_if.sv
`timescale 1ns/1ps

// memory stage to data ram, no handshake
interface mem_bus_if;
    import pipe_pkg::*;

    logic   en;    // access this cycle
    logic   we;    // write at the edge when en is also high
    word_t  addr;  // byte address
    wmask_t wmask; // byte lanes to write
    word_t  wdata; // lane-shifted store data
    word_t  rdata; // addressed word, combinational

    modport master (
        output en, we, addr, wmask, wdata,
        input  rdata
    );

    modport slave (
        input  en, we, addr, wmask, wdata,
        output rdata
    );

endinterface

//--- hdl/mem_stage.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module mem_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  pipe_pkg::word_t    alu_result,
    input  pipe_pkg::word_t    src2,
    input  pipe_pkg::mem_op_t  mem_op,
    input  pipe_pkg::reg_idx_t wreg_index,
    input  logic               wreg_en,
    input  pipe_pkg::word_t    pc,
    input  pipe_pkg::word_t    inst,
    input  logic               is_break,
    mem_bus_if.master          mem,
    stage_if.source            out,
    output pipe_pkg::word_t    byp_data,
    output pipe_pkg::reg_idx_t byp_index,
    output logic               byp_en
);
    import pipe_pkg::*;

    logic        is_mem;
    logic        is_store;
    logic        is_load;
    logic        uns;
    logic        accept;
    logic [1:0]  lane;     // byte offset in the word
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    word_t       load_data;
    word_t       result;

    // stage register
    logic     valid_q;
    word_t    result_q;
    reg_idx_t wreg_index_q;
    logic     wreg_en_q;
    word_t    pc_q;
    word_t    inst_q;
    logic     is_break_q;

    assign is_mem   = mem_op[`MOP_MEM];
    assign is_store = is_mem & mem_op[`MOP_STORE];
    assign is_load  = is_mem & ~mem_op[`MOP_STORE];
    assign uns      = mem_op[`MOP_UNSIGNED];
    assign lane     = alu_result[1:0];

    // empty, or the held item leaves this edge
    assign in_ready = ~valid_q | out.ready;
    assign accept   = in_valid & in_ready;

    // loads read whenever offered, stores write only at the accepting edge
    assign mem.en   = in_valid & is_mem;
    assign mem.we   = is_store & in_ready;
    assign mem.addr = alu_result;

    // store lane mask and replicated data
    always_comb begin
        mem.wmask = '0;
        mem.wdata = src2;
        if (mem_op[`MOP_BYTE]) begin
            mem.wmask = 4'b0001 << lane;
            mem.wdata = {(`PIPE_XLEN/8){src2[7:0]}};
        end else if (mem_op[`MOP_HALF]) begin
            mem.wmask = lane[1] ? 4'b1100 : 4'b0011;  // addr[0] ignored, no trap
            mem.wdata = {(`PIPE_XLEN/16){src2[15:0]}};
        end else if (mem_op[`MOP_WORD]) begin
            mem.wmask = '1;
        end
    end

    // pick the addressed lane out of the read word
    assign ld_byte = mem.rdata[{lane, 3'b000} +: 8];
    assign ld_half = lane[1] ? mem.rdata[31:16] : mem.rdata[15:0];

    always_comb begin
        load_data = mem.rdata;  // word load
        if (mem_op[`MOP_BYTE]) begin
            load_data = {{(`PIPE_XLEN-8){ld_byte[7] & ~uns}}, ld_byte};
        end else if (mem_op[`MOP_HALF]) begin
            load_data = {{(`PIPE_XLEN-16){ld_half[15] & ~uns}}, ld_half};
        end
    end

    assign result = is_load ? load_data : alu_result;

    // towards decode, follows the offered item
    assign byp_data  = result;
    assign byp_index = wreg_index;
    assign byp_en    = in_valid & wreg_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (out.ready) begin
            valid_q <= 1'b0;  // drained
        end
    end

    // payload only moves on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            result_q     <= result;
            wreg_index_q <= wreg_index;
            wreg_en_q    <= wreg_en;
            pc_q         <= pc;
            inst_q       <= inst;
            is_break_q   <= is_break;
        end
    end

    assign out.valid      = valid_q;
    assign out.result     = result_q;
    assign out.wreg_index = wreg_index_q;
    assign out.wreg_en    = wreg_en_q;
    assign out.pc         = pc_q;
    assign out.inst       = inst_q;
    assign out.is_break   = is_break_q;

    a_size_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        (in_valid && is_mem) |->
            $onehot({mem_op[`MOP_BYTE], mem_op[`MOP_HALF], mem_op[`MOP_WORD]}))
        else $error("mem_stage: access size not one-hot");

    // held item must not change until write-back takes it
    a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (out.valid && !out.ready) |=> (out.valid && $stable({out.result,
            out.wreg_index, out.wreg_en, out.pc, out.inst, out.is_break})))
        else $error("mem_stage: payload changed while stalled");

endmodule

//--- hdl/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top (
    input  logic               clk,
    input  logic               arst_n,

    // resolved instruction from execute
    input  logic               in_valid,
    output logic               in_ready,
    input  pipe_pkg::word_t    alu_result,
    input  pipe_pkg::word_t    src2,
    input  pipe_pkg::mem_op_t  mem_op,
    input  pipe_pkg::reg_idx_t wreg_index,
    input  logic               wreg_en,
    input  pipe_pkg::word_t    pc,
    input  pipe_pkg::word_t    inst,
    input  logic               is_break,

    input  logic               stall,       // holds write-back

    // bypass towards decode
    output pipe_pkg::word_t    byp_data,
    output pipe_pkg::reg_idx_t byp_index,
    output logic               byp_en,

    // debug and retire
    input  pipe_pkg::reg_idx_t rf_raddr,
    output pipe_pkg::word_t    rf_rdata,
    output logic               retire_valid,
    output pipe_pkg::word_t    retire_pc,
    output logic               halted
);

    mem_bus_if mem_bus ();
    stage_if   stage_bus ();

    mem_stage u_mem_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .alu_result (alu_result),
        .src2       (src2),
        .mem_op     (mem_op),
        .wreg_index (wreg_index),
        .wreg_en    (wreg_en),
        .pc         (pc),
        .inst       (inst),
        .is_break   (is_break),
        .mem        (mem_bus.master),
        .out        (stage_bus.source),
        .byp_data   (byp_data),
        .byp_index  (byp_index),
        .byp_en     (byp_en)
    );

    data_ram u_data_ram (
        .clk (clk),
        .bus (mem_bus.slave)
    );

    wb_stage u_wb_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .in           (stage_bus.sink),
        .stall        (stall),
        .rf_raddr     (rf_raddr),
        .rf_rdata     (rf_rdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .halted       (halted)
    );

endmodule

//--- hdl/pipe_pkg.sv
`include "pipe_settings.svh"

package pipe_pkg;

    // data, address, pc and instruction words
    typedef logic [`PIPE_XLEN-1:0] word_t;

    // register file index
    typedef logic [$clog2(`PIPE_NREGS)-1:0] reg_idx_t;

    // one bit per byte lane
    typedef logic [`PIPE_XLEN/8-1:0] wmask_t;

    // mem, unsigned, store, word, half, byte
    typedef logic [`MOP_BYTE:0] mem_op_t;

    // word index into the data ram
    typedef logic [$clog2(`PIPE_RAM_WORDS)-1:0] ram_addr_t;

    // write-back control
    typedef enum logic {
        wb_run  = 1'b0, // retiring normally
        wb_halt = 1'b1  // break retired, accept nothing
    } wb_state_e;

endpackage

//--- hdl/pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// data and address width
`define PIPE_XLEN 32

// integer register file entries, x0 included
`define PIPE_NREGS 32

// data ram depth in 32-bit words
`define PIPE_RAM_WORDS 256

// bit positions in the memory-op code
`define MOP_MEM 0
`define MOP_UNSIGNED 1
// set for store, clear for load
`define MOP_STORE 2
// one-hot size field
`define MOP_WORD 3
`define MOP_HALF 4
`define MOP_BYTE 5

`endif

//--- hdl/stage_if.sv
`timescale 1ns/1ps

// memory stage register to write-back stage
interface stage_if;
    import pipe_pkg::*;

    logic     valid;
    logic     ready;
    word_t    result;     // alu result or extended load data
    reg_idx_t wreg_index;
    logic     wreg_en;
    word_t    pc;
    word_t    inst;
    logic     is_break;   // ebreak, halts write-back

    // transfer on a rising edge with valid and ready both high
    modport source (
        output valid, result, wreg_index, wreg_en, pc, inst, is_break,
        input  ready
    );

    modport sink (
        input  valid, result, wreg_index, wreg_en, pc, inst, is_break,
        output ready
    );

endinterface

//--- hdl/wb_stage.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module wb_stage (
    input  logic               clk,
    input  logic               arst_n,
    stage_if.sink              in,
    input  logic               stall,
    input  pipe_pkg::reg_idx_t rf_raddr,
    output pipe_pkg::word_t    rf_rdata,
    output logic               retire_valid,
    output pipe_pkg::word_t    retire_pc,
    output logic               halted
);
    import pipe_pkg::*;

    wb_state_e state_q;
    word_t     rf_q [`PIPE_NREGS];
    logic      fire;
    logic      rf_we;
    logic      retire_q;
    word_t     retire_pc_q;

    // no acceptance once halted
    assign in.ready = ~stall & (state_q == wb_run);
    assign fire     = in.valid & in.ready;
    assign rf_we    = fire & in.wreg_en & (in.wreg_index != '0);  // x0 not writable

    // register file
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PIPE_NREGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (rf_we) begin
            rf_q[in.wreg_index] <= in.result;
        end
    end

    // debug read port
    assign rf_rdata = (rf_raddr == '0) ? '0 : rf_q[rf_raddr];

    // break halt fsm
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= wb_run;
        end else begin
            case (state_q)
                wb_run: begin
                    if (fire && in.is_break) begin
                        state_q <= wb_halt;
                    end
                end
                wb_halt: state_q <= wb_halt;  // left only by reset
                default: state_q <= wb_run;
            endcase
        end
    end

    // retire report, one cycle after the transfer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_q <= 1'b0;
        end else begin
            retire_q <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            retire_pc_q <= in.pc;
        end
    end

    assign retire_valid = retire_q;
    assign retire_pc    = retire_pc_q;
    assign halted       = (state_q == wb_halt);

    // the break itself may write at the edge it moves to halt, nothing after
    a_no_write_halted: assert property (@(posedge clk) disable iff (!arst_n)
        (state_q == wb_halt) |=>
            (rf_q[$past(in.wreg_index)] == $past(rf_q[in.wreg_index])))
        else $error("wb_stage: register write while halted");

    // break flag comes from execute, the word it retires with is ebreak
    a_break_word: assert property (@(posedge clk) disable iff (!arst_n)
        (fire && in.is_break) |-> (in.inst == 32'h0010_0073))
        else $error("wb_stage: break flag on non-ebreak word 0x%08h", in.inst);

endmodule

//--- list.f
+incdir+hdl
hdl/pipe_pkg.sv
hdl/mem_bus_if.sv
hdl/stage_if.sv
hdl/mem_stage.sv
hdl/data_ram.sv
hdl/wb_stage.sv
hdl/mem_wb_top.sv
testbench/tb_mem_wb_top.sv

//--- testbench/tb_mem_wb_top.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module tb_mem_wb_top;
    import pipe_pkg::*;

    localparam int clk_period    = 8;
    localparam int n_alu         = 16;
    localparam int n_word        = 8;   // stores, then as many loads
    localparam int n_sub_bases   = 2;
    localparam int sub_per_base  = 33;  // 7 stores and 26 loads per base word
    localparam int n_stall       = 6;
    localparam int n_break       = 2;
    localparam int total_items   = n_alu + 2 * n_word + n_sub_bases * sub_per_base
                                   + n_stall + n_break;
    localparam int margin_cycles = 1000;  // reset, register readback, stall window
    localparam int drain_limit   = 50;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    logic     in_ready;
    word_t    alu_result;
    word_t    src2;
    mem_op_t  mem_op;
    reg_idx_t wreg_index;
    logic     wreg_en;
    word_t    pc;
    word_t    inst;
    logic     is_break;
    logic     stall;
    word_t    byp_data;
    reg_idx_t byp_index;
    logic     byp_en;
    reg_idx_t rf_raddr;
    word_t    rf_rdata;
    logic     retire_valid;
    word_t    retire_pc;
    logic     halted;

    // reference model
    word_t      model_rf [32];
    logic [7:0] model_ram [1024];  // byte view of the 256-word ram
    word_t      exp_pcs [$];       // pcs still due on retire_valid, oldest first
    word_t      next_pc;
    int         errors;
    int         checks_done;
    bit         saw_backpressure;

    mem_wb_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((total_items * 20 + margin_cycles) * clk_period);
        $display("timeout: the pipeline stopped making progress before all tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check(input string name, input word_t expected, input word_t actual);
        checks_done++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    function automatic mem_op_t load_op(input int size, input bit uns);
        mem_op_t op;
        op = '0;
        op[`MOP_MEM]      = 1'b1;
        op[`MOP_UNSIGNED] = uns;
        op[`MOP_BYTE]     = (size == 1);
        op[`MOP_HALF]     = (size == 2);
        op[`MOP_WORD]     = (size == 4);
        return op;
    endfunction

    function automatic mem_op_t store_op(input int size);
        mem_op_t op;
        op = load_op(size, 1'b0);
        op[`MOP_STORE] = 1'b1;
        return op;
    endfunction

    // value the item should write back: extended load data or the alu result
    function automatic word_t model_result(input word_t addr, input mem_op_t op);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        a = addr[9:0];
        if (!op[`MOP_MEM] || op[`MOP_STORE]) return addr;
        b = model_ram[a];
        h = {model_ram[{a[9:1], 1'b1}], model_ram[{a[9:1], 1'b0}]};
        if (op[`MOP_BYTE]) return op[`MOP_UNSIGNED] ? {24'b0, b} : {{24{b[7]}}, b};
        if (op[`MOP_HALF]) return op[`MOP_UNSIGNED] ? {16'b0, h} : {{16{h[15]}}, h};
        return {model_ram[{a[9:2], 2'd3}], model_ram[{a[9:2], 2'd2}],
                model_ram[{a[9:2], 2'd1}], model_ram[{a[9:2], 2'd0}]};
    endfunction

    function automatic void model_store(input word_t addr, input word_t data,
                                        input mem_op_t op);
        logic [9:0] a;
        a = addr[9:0];
        if (op[`MOP_BYTE]) begin
            model_ram[a] = data[7:0];
        end else if (op[`MOP_HALF]) begin
            model_ram[{a[9:1], 1'b0}] = data[7:0];
            model_ram[{a[9:1], 1'b1}] = data[15:8];
        end else begin
            for (int i = 0; i < 4; i++) model_ram[{a[9:2], 2'(i)}] = data[8 * i +: 8];
        end
    endfunction

    // offer one item, check the bypass each cycle, return after the accepting edge
    task automatic issue(input string name, input word_t alu, input word_t s2,
                         input mem_op_t op, input reg_idx_t rd, input logic we,
                         input logic brk, input bit retires);
        word_t expd;
        word_t cur_pc;
        bit    accepted;
        cur_pc   = next_pc;
        next_pc  = next_pc + 32'd4;
        expd     = model_result(alu, op);
        accepted = 1'b0;
        @(posedge clk);
        in_valid   <= 1'b1;
        alu_result <= alu;
        src2       <= s2;
        mem_op     <= op;
        wreg_index <= rd;
        wreg_en    <= we;
        pc         <= cur_pc;
        inst       <= brk ? 32'h0010_0073 : $urandom;  // ebreak encoding
        is_break   <= brk;
        while (!accepted) begin
            @(negedge clk);
            check({name, " bypass data"}, expd, byp_data);
            check({name, " bypass index"}, word_t'(rd), word_t'(byp_index));
            check({name, " bypass enable"}, word_t'(we), word_t'(byp_en));
            if (!in_ready) saw_backpressure = 1'b1;
            accepted = in_ready;  // inputs only move at posedge, so this holds for the edge
            @(posedge clk);
        end
        in_valid <= 1'b0;
        if (op[`MOP_MEM] && op[`MOP_STORE]) model_store(alu, s2, op);
        if (retires) begin
            exp_pcs.push_back(cur_pc);
            if (we && rd != '0) model_rf[rd] = expd;
        end
    endtask

    // each retire must be the oldest outstanding pc
    always @(negedge clk) begin
        if (arst_n && retire_valid) begin
            if (exp_pcs.size() == 0) begin
                errors++;
                $display("retire_valid pulsed for pc 0x%08h with nothing outstanding", retire_pc);
            end else begin
                check("retire pc", exp_pcs.pop_front(), retire_pc);
            end
        end
    end

    task automatic wait_retired(input string name);
        int cycles;
        cycles = 0;
        while (exp_pcs.size() != 0 && cycles < drain_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_pcs.size() != 0) begin
            errors++;
            $display("%s: %0d instructions never retired", name, exp_pcs.size());
        end
    endtask

    task automatic check_regs(input string name);
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            rf_raddr <= reg_idx_t'(i);
            @(negedge clk);
            check({name, " register"}, model_rf[i], rf_rdata);
        end
    endtask

    task automatic test_alu();
        reg_idx_t rd;
        for (int i = 0; i < n_alu; i++) begin
            rd = (i == 3) ? '0 : reg_idx_t'($urandom % 32);  // one write aimed at x0
            issue("alu", $urandom, $urandom, '0, rd, 1'b1, 1'b0, 1'b1);
        end
        wait_retired("alu");
        check_regs("alu");
    endtask

    task automatic test_word();
        word_t addrs [n_word];
        for (int i = 0; i < n_word; i++) begin
            addrs[i] = word_t'(($urandom % 256) << 2);
            issue("word store", addrs[i], $urandom, store_op(4), '0, 1'b0, 1'b0, 1'b1);
        end
        for (int i = 0; i < n_word; i++) begin
            issue("word load", addrs[i], '0, load_op(4, 1'b0), reg_idx_t'(i + 1),
                  1'b1, 1'b0, 1'b1);
        end
        wait_retired("word");
        check_regs("word");
    endtask

    // word, both halves and all bytes, signed and unsigned, into x1..x13
    task automatic load_every_lane(input string name, input word_t base);
        reg_idx_t rd;
        rd = 5'd1;
        issue(name, base, '0, load_op(4, 1'b0), rd, 1'b1, 1'b0, 1'b1);
        for (int lane = 0; lane < 4; lane += 2) begin
            for (int u = 0; u < 2; u++) begin
                rd++;
                issue(name, base + word_t'(lane), '0, load_op(2, u[0]), rd, 1'b1, 1'b0, 1'b1);
            end
        end
        for (int lane = 0; lane < 4; lane++) begin
            for (int u = 0; u < 2; u++) begin
                rd++;
                issue(name, base + word_t'(lane), '0, load_op(1, u[0]), rd, 1'b1, 1'b0, 1'b1);
            end
        end
        wait_retired(name);
        check_regs(name);
    endtask

    task automatic test_subword();
        word_t base;
        word_t data;
        for (int k = 0; k < n_sub_bases; k++) begin
            base = word_t'(($urandom % 256) << 2);
            issue("subword store word", base, $urandom, store_op(4), '0, 1'b0, 1'b0, 1'b1);
            for (int lane = 0; lane < 4; lane++) begin
                data    = $urandom;
                data[7] = lane[0];  // both byte signs
                issue("subword store byte", base + word_t'(lane), data, store_op(1), '0,
                      1'b0, 1'b0, 1'b1);
            end
            load_every_lane("subword after byte stores", base);
            for (int lane = 0; lane < 4; lane += 2) begin
                data     = $urandom;
                data[15] = lane[1];
                issue("subword store half", base + word_t'(lane), data, store_op(2), '0,
                      1'b0, 1'b0, 1'b1);
            end
            load_every_lane("subword after half stores", base);
        end
    endtask

    task automatic test_backpressure();
        word_t addr;
        addr             = word_t'(($urandom % 256) << 2);
        saw_backpressure = 1'b0;
        @(posedge clk);
        stall <= 1'b1;
        fork
            begin
                repeat (12) @(posedge clk);
                stall <= 1'b0;
            end
        join_none
        issue("stall store word", addr, $urandom, store_op(4), '0, 1'b0, 1'b0, 1'b1);
        issue("stall alu", $urandom, '0, '0, 5'd7, 1'b1, 1'b0, 1'b1);
        issue("stall store byte", addr + 32'd1, $urandom, store_op(1), '0, 1'b0, 1'b0, 1'b1);
        issue("stall load word", addr, '0, load_op(4, 1'b0), 5'd8, 1'b1, 1'b0, 1'b1);
        issue("stall alu", $urandom, '0, '0, 5'd9, 1'b1, 1'b0, 1'b1);
        issue("stall load byte", addr + 32'd1, '0, load_op(1, 1'b1), 5'd10, 1'b1, 1'b0, 1'b1);
        wait_retired("stall");
        if (!saw_backpressure) begin
            errors++;
            $display("stall: in_ready never fell while write-back was stalled");
        end
        check_regs("stall");
    endtask

    task automatic test_break();
        word_t brk_pc;
        brk_pc = next_pc;
        issue("break", '0, '0, '0, '0, 1'b0, 1'b1, 1'b1);
        issue("after break", $urandom, '0, '0, 5'd12, 1'b1, 1'b0, 1'b0);  // must not retire
        wait_retired("break");
        repeat (10) @(posedge clk);  // window in which nothing may retire
        @(negedge clk);
        check("break halted", 32'd1, word_t'(halted));
        check("break retire pc", brk_pc, retire_pc);
        check("break in_ready", 32'd0, word_t'(in_ready));
        check_regs("break");
    endtask

    initial begin
        void'($urandom(32'h3405_029f));
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        alu_result = '0;
        src2       = '0;
        mem_op     = '0;
        wreg_index = '0;
        wreg_en    = 1'b0;
        pc         = '0;
        inst       = '0;
        is_break   = 1'b0;
        stall      = 1'b0;
        rf_raddr   = '0;
        next_pc    = 32'h0000_1000;
        errors     = 0;
        checks_done = 0;
        for (int i = 0; i < 32; i++) model_rf[i] = '0;
        for (int i = 0; i < 1024; i++) model_ram[i] = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check("reset halted", 32'd0, word_t'(halted));
        check("reset retire_valid", 32'd0, word_t'(retire_valid));
        check_regs("reset");
        test_alu();
        test_word();
        test_subword();
        test_backpressure();
        test_break();
        $display("tb_mem_wb_top: %0d checks, %0d errors", checks_done, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
